// File: src/tq_defines.svh
`ifndef TQ_DEFINES_SVH
`define TQ_DEFINES_SVH

// Task field widths
`define TQ_TS_WIDTH 16
`define TQ_TTYPE_WIDTH 4
`define TQ_LOCALE_WIDTH 16
`define TQ_ARG_WIDTH 16

// Store sizing
`define TQ_DEPTH 16
`define TQ_SPILL_THRESHOLD 12

// Spill burst and overflow buffering
`define TQ_SPILL_SIZE 4
`define TQ_FIFO_DEPTH 8

// Task type routed to the splitter port
`define TQ_SPLITTER_TTYPE 15

`endif

// File: src/tq_pkg.sv
`default_nettype none

`include "tq_defines.svh"

package tq_pkg;

   typedef logic [`TQ_TS_WIDTH-1:0] ts_t;
   typedef logic [`TQ_TTYPE_WIDTH-1:0] ttype_t;

   // Timestamp sits in the top bits
   typedef struct packed {
      ts_t ts;
      ttype_t ttype;
      logic [`TQ_LOCALE_WIDTH-1:0] locale;
      logic [`TQ_ARG_WIDTH-1:0] args;
   } task_t;

   // Occupancy 0 to TQ_DEPTH inclusive
   typedef logic [4:0] count_t;
   typedef logic [2:0] spill_cnt_t;

   typedef enum logic [2:0] {
      NOP,
      ENQ,
      DEQ_MIN,
      REPLACE,
      DEQ_MAX
   } heap_op_t;

endpackage

`default_nettype wire

// File: src/store_if.sv
`timescale 1ns/1ps
`default_nettype none

interface store_if;
   import tq_pkg::*;

   // From the controller
   heap_op_t op;
   task_t ins_task;

   // From the store
   task_t min_task;
   task_t max_task;
   logic min_valid;
   count_t count;

   // From the spill FIFO
   logic fifo_room;

   modport ctrl (output op, ins_task, input min_task, min_valid, count, fifo_room);

   modport store (input op, ins_task, output min_task, max_task, min_valid, count);

   modport fifo (input op, max_task, output fifo_room);

endinterface

`default_nettype wire

// File: src/insert_stage.sv
`timescale 1ns/1ps
`default_nettype none

module insert_stage (
   input wire logic clk,
   input wire logic rstn,
   input wire logic task_enq_valid,
   input wire tq_pkg::task_t task_enq_data,
   input wire logic coal_child_valid,
   input wire tq_pkg::task_t coal_child_data,
   input wire logic block,
   input wire logic consume,
   output logic task_enq_ready,
   output logic coal_child_ready,
   output logic held_valid,
   output tq_pkg::task_t held_task
);
   import tq_pkg::*;

   logic take;
   logic accept;

   // Only an empty register may take a new task
   assign take = !held_valid && !block;

   // Coalescer children win over ordinary enqueues
   assign coal_child_ready = take && coal_child_valid;
   assign task_enq_ready = take && !coal_child_valid;

   assign accept = (coal_child_valid && coal_child_ready) || (task_enq_valid && task_enq_ready);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held_valid <= 1'b0;
      end else if (accept) begin
         held_valid <= 1'b1;
      end else if (consume) begin
         held_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         held_task <= coal_child_valid ? coal_child_data : task_enq_data;
      end
   end

   a_one_source: assert property (@(posedge clk) disable iff (!rstn)
      !(coal_child_ready && task_enq_ready));

endmodule

`default_nettype wire

// File: src/heap_op_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module heap_op_ctrl (
   input wire logic clk,
   input wire logic rstn,
   input wire logic held_valid,
   input wire tq_pkg::task_t held_task,
   input wire logic task_deq_ready,
   input wire logic splitter_deq_ready,
   input wire logic start,
   input wire tq_pkg::ts_t throttle_margin,
   input wire tq_pkg::ts_t gvt,
   input wire logic burst_done,
   output logic consume,
   output logic block,
   output logic burst_load,
   output logic task_deq_valid,
   output logic splitter_deq_valid,
   store_if.ctrl sif
);
   import tq_pkg::*;

   typedef enum logic {RUN, SPILL} state_e;

   state_e state;
   logic is_splitter;
   logic throttle_ok;
   logic store_full;
   logic deq;
   logic [`TQ_TS_WIDTH:0] throttle_lim;

   // Extra bit so gvt plus margin cannot wrap
   assign throttle_lim = {1'b0, gvt} + {1'b0, throttle_margin};
   assign throttle_ok = (throttle_margin == '0) || ({1'b0, sif.min_task.ts} < throttle_lim);

   assign is_splitter = sif.min_task.ttype == ttype_t'(`TQ_SPLITTER_TTYPE);
   assign store_full = sif.count == count_t'(`TQ_DEPTH);

   assign task_deq_valid = sif.min_valid && (state == RUN) && !is_splitter && start && throttle_ok;
   assign splitter_deq_valid = sif.min_valid && (state == RUN) && is_splitter;

   assign deq = (task_deq_valid && task_deq_ready) || (splitter_deq_valid && splitter_deq_ready);

   assign burst_load = (state == RUN) && (sif.count > count_t'(`TQ_SPILL_THRESHOLD));
   assign block = (state == SPILL) || store_full;
   assign sif.ins_task = held_task;

   always_comb begin
      sif.op = NOP;
      if (state == SPILL) begin
         // Stall while the overflow side is backed up
         if (!burst_done && sif.fifo_room && sif.min_valid) begin
            sif.op = DEQ_MAX;
         end
      end else if (held_valid && deq) begin
         sif.op = REPLACE;
      end else if (held_valid && !store_full) begin
         sif.op = ENQ;
      end else if (deq) begin
         sif.op = DEQ_MIN;
      end
   end

   assign consume = (sif.op == ENQ) || (sif.op == REPLACE);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= RUN;
      end else if (burst_load) begin
         state <= SPILL;
      end else if ((state == SPILL) && burst_done) begin
         state <= RUN;
      end
   end

   a_no_max_in_run: assert property (@(posedge clk) disable iff (!rstn)
      (state == RUN) |-> (sif.op != DEQ_MAX));

endmodule

`default_nettype wire

// File: src/spill_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module spill_counter (
   input wire logic clk,
   input wire logic rstn,
   input wire logic load,
   input wire tq_pkg::heap_op_t op,
   output logic done
);
   import tq_pkg::*;

   spill_cnt_t remaining;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining <= '0;
      end else if (load) begin
         remaining <= spill_cnt_t'(`TQ_SPILL_SIZE);
      end else if ((op == DEQ_MAX) && (remaining != '0)) begin
         remaining <= remaining - 1'b1;
      end
   end

   // Idle counter reads as done
   assign done = remaining == '0;

   a_load_idle: assert property (@(posedge clk) disable iff (!rstn)
      load |-> done);

endmodule

`default_nettype wire

// File: src/task_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module task_store (
   input wire logic clk,
   input wire logic rstn,
   store_if.store sif
);
   import tq_pkg::*;

   localparam int IDX_W = $clog2(`TQ_DEPTH);

   typedef logic [IDX_W-1:0] idx_t;

   task_t entries [`TQ_DEPTH];
   logic [`TQ_DEPTH-1:0] vld;

   idx_t min_idx;
   idx_t max_idx;
   idx_t free_idx;
   logic min_hit;
   logic max_hit;

   // Linear scan over the live entries
   always_comb begin
      min_idx = '0;
      max_idx = '0;
      min_hit = 1'b0;
      max_hit = 1'b0;
      for (int i = 0; i < `TQ_DEPTH; i++) begin
         if (vld[i]) begin
            if (!min_hit || (entries[i].ts < entries[min_idx].ts)) begin
               min_idx = idx_t'(i);
            end
            if (!max_hit || (entries[i].ts >= entries[max_idx].ts)) begin
               max_idx = idx_t'(i);
            end
            min_hit = 1'b1;
            max_hit = 1'b1;
         end
      end
   end

   // Lowest free slot wins
   always_comb begin
      free_idx = '0;
      for (int i = `TQ_DEPTH - 1; i >= 0; i--) begin
         if (!vld[i]) begin
            free_idx = idx_t'(i);
         end
      end
   end

   assign sif.min_task = entries[min_idx];
   assign sif.max_task = entries[max_idx];
   assign sif.min_valid = min_hit;
   assign sif.count = count_t'($countones(vld));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         vld <= '0;
      end else begin
         case (sif.op)
            ENQ: vld[free_idx] <= 1'b1;
            DEQ_MIN: vld[min_idx] <= 1'b0;
            DEQ_MAX: vld[max_idx] <= 1'b0;
            default: ;
         endcase
      end
   end

   // REPLACE reuses the slot of the departing minimum
   always_ff @(posedge clk) begin
      if (sif.op == ENQ) begin
         entries[free_idx] <= sif.ins_task;
      end else if (sif.op == REPLACE) begin
         entries[min_idx] <= sif.ins_task;
      end
   end

   a_enq_not_full: assert property (@(posedge clk) disable iff (!rstn)
      (sif.op == ENQ) |-> (sif.count != count_t'(`TQ_DEPTH)));

   a_deq_not_empty: assert property (@(posedge clk) disable iff (!rstn)
      (sif.op inside {DEQ_MIN, DEQ_MAX, REPLACE}) |-> sif.min_valid);

endmodule

`default_nettype wire

// File: src/spill_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module spill_fifo (
   input wire logic clk,
   input wire logic rstn,
   store_if.fifo sif,
   input wire logic overflow_ready,
   output logic overflow_valid,
   output tq_pkg::task_t overflow_data
);
   import tq_pkg::*;

   localparam int PTR_W = $clog2(`TQ_FIFO_DEPTH);

   task_t buffer [`TQ_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0] occ;
   logic wr;
   logic rd;

   assign wr = sif.op == DEQ_MAX;
   assign rd = overflow_valid && overflow_ready;

   assign sif.fifo_room = occ != (PTR_W + 1)'(`TQ_FIFO_DEPTH);
   assign overflow_valid = occ != '0;
   assign overflow_data = buffer[rd_ptr];

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         occ <= occ + (PTR_W + 1)'(wr) - (PTR_W + 1)'(rd);
      end
   end

   always_ff @(posedge clk) begin
      if (wr) begin
         buffer[wr_ptr] <= sif.max_task;
      end
   end

   a_no_write_full: assert property (@(posedge clk) disable iff (!rstn)
      wr |-> sif.fifo_room);

endmodule

`default_nettype wire

// File: src/task_unit_nonspec.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module task_unit_nonspec (
   input wire logic clk,
   input wire logic rstn,
   input wire logic task_enq_valid,
   output logic task_enq_ready,
   input wire tq_pkg::task_t task_enq_data,
   input wire logic coal_child_valid,
   output logic coal_child_ready,
   input wire tq_pkg::task_t coal_child_data,
   output logic task_deq_valid,
   input wire logic task_deq_ready,
   output tq_pkg::task_t task_deq_data,
   output logic splitter_deq_valid,
   input wire logic splitter_deq_ready,
   output tq_pkg::task_t splitter_deq_task,
   output logic overflow_valid,
   input wire logic overflow_ready,
   output tq_pkg::task_t overflow_data,
   input wire logic start,
   input wire tq_pkg::ts_t throttle_margin,
   input wire tq_pkg::ts_t gvt,
   output logic full,
   output logic almost_full,
   output logic empty,
   output tq_pkg::ts_t lvt
);
   import tq_pkg::*;

   logic held_valid;
   task_t held_task;
   logic consume;
   logic block;
   logic burst_load;
   logic burst_done;

   store_if sif ();

   insert_stage i_insert (
      .clk(clk),
      .rstn(rstn),
      .task_enq_valid(task_enq_valid),
      .task_enq_data(task_enq_data),
      .coal_child_valid(coal_child_valid),
      .coal_child_data(coal_child_data),
      .block(block),
      .consume(consume),
      .task_enq_ready(task_enq_ready),
      .coal_child_ready(coal_child_ready),
      .held_valid(held_valid),
      .held_task(held_task)
   );

   heap_op_ctrl i_ctrl (
      .clk(clk),
      .rstn(rstn),
      .held_valid(held_valid),
      .held_task(held_task),
      .task_deq_ready(task_deq_ready),
      .splitter_deq_ready(splitter_deq_ready),
      .start(start),
      .throttle_margin(throttle_margin),
      .gvt(gvt),
      .burst_done(burst_done),
      .consume(consume),
      .block(block),
      .burst_load(burst_load),
      .task_deq_valid(task_deq_valid),
      .splitter_deq_valid(splitter_deq_valid),
      .sif(sif.ctrl)
   );

   spill_counter i_spill_cnt (
      .clk(clk),
      .rstn(rstn),
      .load(burst_load),
      .op(sif.op),
      .done(burst_done)
   );

   task_store i_store (
      .clk(clk),
      .rstn(rstn),
      .sif(sif.store)
   );

   spill_fifo i_fifo (
      .clk(clk),
      .rstn(rstn),
      .sif(sif.fifo),
      .overflow_ready(overflow_ready),
      .overflow_valid(overflow_valid),
      .overflow_data(overflow_data)
   );

   // Both dequeue ports show the current minimum
   assign task_deq_data = sif.min_task;
   assign splitter_deq_task = sif.min_task;

   assign empty = sif.count == '0;
   assign almost_full = sif.count > count_t'(`TQ_SPILL_THRESHOLD);
   assign full = sif.count == count_t'(`TQ_DEPTH);
   assign lvt = sif.min_valid ? sif.min_task.ts : '1;

endmodule

`default_nettype wire

// File: verif/tb_task_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "tq_defines.svh"

module tb_task_unit;
   import tq_pkg::*;

   localparam int RAND_CYCLES = 600;
   localparam int GATE_CYCLES = 150;
   localparam int SPILL_CYCLES = 200;
   localparam int FLUSH_CYCLES = 40;
   localparam int DRAIN_LIMIT = 500;
   localparam int WATCHDOG_CYCLES = 2 * (5 + RAND_CYCLES + 2 * GATE_CYCLES + SPILL_CYCLES
      + FLUSH_CYCLES + DRAIN_LIMIT) + 100;
   localparam ttype_t SPLIT = ttype_t'(`TQ_SPLITTER_TTYPE);

   logic clk;
   logic rstn;
   logic task_enq_valid;
   logic task_enq_ready;
   task_t task_enq_data;
   logic coal_child_valid;
   logic coal_child_ready;
   task_t coal_child_data;
   logic task_deq_valid;
   logic task_deq_ready;
   task_t task_deq_data;
   logic splitter_deq_valid;
   logic splitter_deq_ready;
   task_t splitter_deq_task;
   logic overflow_valid;
   logic overflow_ready;
   task_t overflow_data;
   logic start;
   ts_t throttle_margin;
   ts_t gvt;
   logic full;
   logic almost_full;
   logic empty;
   ts_t lvt;

   // Reference model of every task accepted and not yet seen leaving
   task_t model[$];
   task_t last_task;
   logic last_live;
   logic [15:0] seq;
   ts_t prev_ovf_ts;
   int burst_pos;
   int n_in;
   int n_out;
   int n_ovf;
   logic seen_af;
   int errs;
   int total_errs;
   int tests_run;
   int tests_failed;
   string test_name;

   task_unit_nonspec i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
      $display("Regression failed");
      $finish;
   end

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
      errs++;
      total_errs++;
   endtask

   task automatic report_problem(input string what);
      $display("Error in test %s: %s", test_name, what);
      errs++;
      total_errs++;
   endtask

   function automatic task_t next_task();
      task_t t;
      logic [31:0] r;
      logic [31:0] k;
      r = $urandom;
      k = $urandom;
      t.ts = r[15:0];
      t.locale = r[31:16];
      // Roughly one task in four goes to the splitter
      t.ttype = (k[1:0] == 2'd0) ? SPLIT : ttype_t'(k[7:4] % 4'd15);
      t.args = seq;
      seq = seq + 1'b1;
      return t;
   endfunction

   function automatic int find_task(input task_t t);
      for (int i = 0; i < model.size(); i++) begin
         if (model[i] == t) begin
            return i;
         end
      end
      return -1;
   endfunction

   // Skipping the last accepted task covers the one still in the insert register
   function automatic logic [`TQ_TS_WIDTH:0] lowest_ts(input logic skip_held);
      logic [`TQ_TS_WIDTH:0] m;
      logic skipped;
      m = '1;
      skipped = 1'b0;
      for (int i = 0; i < model.size(); i++) begin
         if (skip_held && last_live && !skipped && model[i] == last_task) begin
            skipped = 1'b1;
         end else if ({1'b0, model[i].ts} < m) begin
            m = {1'b0, model[i].ts};
         end
      end
      return m;
   endfunction

   task automatic remove_task(input int idx);
      if (model[idx] == last_task) begin
         last_live = 1'b0;
      end
      model.delete(idx);
      n_out++;
   endtask

   task automatic check_dequeue(input task_t t);
      int idx;
      logic [`TQ_TS_WIDTH:0] m_all;
      logic [`TQ_TS_WIDTH:0] m_excl;
      idx = find_task(t);
      m_all = lowest_ts(1'b0);
      m_excl = lowest_ts(1'b1);
      if (idx < 0) begin
         report_problem("dequeued task is not in the model");
      end else begin
         if ({1'b0, t.ts} != m_all && {1'b0, t.ts} != m_excl) begin
            report_mismatch("dequeue ts", m_excl, t.ts);
         end
         remove_task(idx);
      end
   endtask

   task automatic check_overflow(input task_t t);
      int idx;
      idx = find_task(t);
      if (idx < 0) begin
         report_problem("spilled task is not in the model");
      end else begin
         remove_task(idx);
      end
      // Every burst moves exactly TQ_SPILL_SIZE tasks, largest first
      if (burst_pos != 0 && t.ts > prev_ovf_ts) begin
         report_mismatch("spill order ts", prev_ovf_ts, t.ts);
      end
      prev_ovf_ts = t.ts;
      burst_pos = (burst_pos + 1) % `TQ_SPILL_SIZE;
      n_ovf++;
   endtask

   always @(posedge clk) begin
      if (rstn) begin
         if (almost_full) begin
            seen_af = 1'b1;
         end
         if (coal_child_ready && task_enq_ready) begin
            report_problem("both input readies high together");
         end
         if (coal_child_valid && task_enq_valid && task_enq_ready) begin
            report_problem("enqueue accepted while a coalescer child waits");
         end
         if (!start && task_deq_valid) begin
            report_problem("commit-queue dequeue offered with start low");
         end
         if (throttle_margin != '0 && task_deq_valid
             && ({1'b0, task_deq_data.ts} >= {1'b0, gvt} + {1'b0, throttle_margin})) begin
            report_problem("task offered at or above gvt plus margin");
         end
         if (splitter_deq_valid && splitter_deq_task.ttype != SPLIT) begin
            report_mismatch("splitter ttype", SPLIT, splitter_deq_task.ttype);
         end
         if (task_deq_valid && task_deq_data.ttype == SPLIT) begin
            report_problem("splitter task offered on the commit-queue port");
         end
         if (overflow_valid && overflow_ready) begin
            check_overflow(overflow_data);
         end
         if (task_deq_valid && task_deq_ready) begin
            check_dequeue(task_deq_data);
         end
         if (splitter_deq_valid && splitter_deq_ready) begin
            check_dequeue(splitter_deq_task);
         end
         if ((coal_child_valid && coal_child_ready) || (task_enq_valid && task_enq_ready)) begin
            last_task = coal_child_ready ? coal_child_data : task_enq_data;
            last_live = 1'b1;
            model.push_back(last_task);
            n_in++;
         end
      end
   end

   // Valids hold their task until the handshake
   task automatic drive_cycle(input int enq_pct, input int deq_pct, input int ovf_pct);
      @(posedge clk);
      if (!coal_child_valid || coal_child_ready) begin
         coal_child_valid <= ($urandom % 100) < enq_pct / 3;
         coal_child_data <= next_task();
      end
      if (!task_enq_valid || task_enq_ready) begin
         task_enq_valid <= ($urandom % 100) < enq_pct;
         task_enq_data <= next_task();
      end
      task_deq_ready <= ($urandom % 100) < deq_pct;
      splitter_deq_ready <= ($urandom % 100) < deq_pct;
      overflow_ready <= ($urandom % 100) < ovf_pct;
   endtask

   task automatic set_levels(input logic st, input ts_t margin, input ts_t time_now);
      @(posedge clk);
      start <= st;
      throttle_margin <= margin;
      gvt <= time_now;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errs = 0;
      n_ovf = 0;
      seen_af = 1'b0;
   endtask

   task automatic end_test();
      @(negedge clk);
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %-10s %s (%0d errors)", test_name, (errs == 0) ? "ok" : "FAILED", errs);
   endtask

   initial begin
      int waited;
      void'($urandom(32'h78362381));
      rstn = 1'b0;
      task_enq_valid = 1'b0;
      task_enq_data = '0;
      coal_child_valid = 1'b0;
      coal_child_data = '0;
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready = 1'b0;
      start = 1'b0;
      throttle_margin = '0;
      gvt = '0;
      last_task = '0;
      last_live = 1'b0;
      seq = '0;
      prev_ovf_ts = '0;
      burst_pos = 0;
      n_in = 0;
      n_out = 0;
      total_errs = 0;
      tests_run = 0;
      tests_failed = 0;
      begin_test("reset");
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      if (empty !== 1'b1) begin
         report_mismatch("empty", 1, empty);
      end
      if (almost_full !== 1'b0) begin
         report_mismatch("almost_full", 0, almost_full);
      end
      if (lvt !== '1) begin
         report_mismatch("lvt", 16'hffff, lvt);
      end
      if (task_deq_valid || splitter_deq_valid || overflow_valid || full) begin
         report_problem("valid or full output high after reset");
      end
      end_test();

      begin_test("random");
      set_levels(1'b1, '0, '0);
      repeat (RAND_CYCLES) drive_cycle(60, 70, 100);
      end_test();

      begin_test("start_gate");
      set_levels(1'b0, '0, '0);
      repeat (GATE_CYCLES) drive_cycle(60, 70, 100);
      end_test();

      begin_test("throttle");
      set_levels(1'b1, ts_t'(1 + $urandom % 4096), ts_t'($urandom));
      repeat (GATE_CYCLES) drive_cycle(60, 70, 100);
      end_test();

      // No dequeues here, so back-pressure on overflow cannot hide a task from the model
      begin_test("spill");
      set_levels(1'b1, '0, '0);
      repeat (SPILL_CYCLES) drive_cycle(100, 0, 50);
      repeat (FLUSH_CYCLES) drive_cycle(0, 0, 100);
      if (!seen_af) begin
         report_problem("almost_full never rose while the store filled");
      end
      if (n_ovf == 0) begin
         report_problem("no task reached the overflow port");
      end
      end_test();

      begin_test("drain");
      set_levels(1'b1, '0, '0);
      @(negedge clk);
      waited = 0;
      while ((n_in != n_out || !empty || task_enq_valid || coal_child_valid)
             && waited < DRAIN_LIMIT) begin
         drive_cycle(0, 100, 100);
         @(negedge clk);
         waited++;
      end
      if (waited >= DRAIN_LIMIT) begin
         report_problem("store did not drain in time");
      end
      if (n_in != n_out) begin
         report_mismatch("tasks out", n_in, n_out);
      end
      if (empty !== 1'b1) begin
         report_mismatch("empty", 1, empty);
      end
      if (almost_full !== 1'b0) begin
         report_mismatch("almost_full", 0, almost_full);
      end
      if (full !== 1'b0) begin
         report_mismatch("full", 0, full);
      end
      if (lvt !== '1) begin
         report_mismatch("lvt", 16'hffff, lvt);
      end
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
      if (tests_failed == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/tq_pkg.sv
src/store_if.sv
src/insert_stage.sv
src/heap_op_ctrl.sv
src/spill_counter.sv
src/task_store.sv
src/spill_fifo.sv
src/task_unit_nonspec.sv
verif/tb_task_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_task_unit \
   -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^Regression passed$" && exit 0 || exit 1
